// ==== compile.f ====
tcb_sub_pkg.sv
tcb_rsp_dly.sv
tcb_sram.sv
tcb_regs.sv
tcb_dec.sv
tcb_top.sv
tcb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the TCB subsystem testbench with Verilator
# exit status is the simulator's, nonzero on failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f compile.f --top-module tcb_tb -o tcb_sim \
  && ./obj_dir/tcb_sim \
  || exit 1

// ==== tcb_dec.sv ====
//////////////////////////////
// TCB address decoder
// routes requests, merges responses, errors unmapped
//////////////////////////////

`timescale 1ns/1ps

module tcb_dec #(
  // response delay
  parameter int unsigned DLY = 1
)(
  input  logic                              tcb,
  input  logic                              rst_n_i,
  // outside request and response
  input  logic                              vld_i,
  input  logic [tcb_sub_pkg::TCB_ABW-1:0]   adr_i,
  output logic                              rdy_o,
  output logic                              rsp_o,
  output logic [tcb_sub_pkg::TCB_DBW-1:0]   rdt_o,
  output logic                              err_o,
  // per target request valid
  output logic                              sram_vld_o,
  output logic                              regs_vld_o,
  // sram response
  input  logic                              sram_rsp_i,
  input  logic [tcb_sub_pkg::TCB_DBW-1:0]   sram_rdt_i,
  input  logic                              sram_err_i,
  // register block response
  input  logic                              regs_rsp_i,
  input  logic [tcb_sub_pkg::TCB_DBW-1:0]   regs_rdt_i,
  input  logic                              regs_err_i
);

  import tcb_sub_pkg::*;

  // target select encoding
  localparam logic [1:0] SEL_SRAM = 2'd0;
  localparam logic [1:0] SEL_REGS = 2'd1;
  localparam logic [1:0] SEL_NONE = 2'd2;

  logic       rdy_q;
  logic       trn;
  logic       sram_hit;
  logic       regs_hit;
  logic [1:0] sel_d;
  logic [1:0] sel_q;
  logic       dly_vld;
  logic       tgt_rsp;

//////////////////////////////
// request side
//////////////////////////////

  // ready rises on the first edge after reset and stays up
  always_ff @(posedge tcb or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign rdy_o = rdy_q;
  assign trn   = vld_i & rdy_q;

  // sram: upper address bits above the word range all zero
  assign sram_hit = (adr_i[TCB_ABW-1:SRAM_AW+2] == '0);
  assign regs_hit = ((adr_i & REGS_MASK) == REGS_BASE);

  assign sel_d = sram_hit ? SEL_SRAM : (regs_hit ? SEL_REGS : SEL_NONE);

  // one target per transfer
  assign sram_vld_o = trn & sram_hit;
  assign regs_vld_o = trn & regs_hit;

//////////////////////////////
// response side
//////////////////////////////

  tcb_rsp_dly #(
    .DLY       (DLY),
    .payload_t (logic [1:0])
  ) u_sel_dly (
    .tcb     (tcb),
    .rst_n_i (rst_n_i),
    .trn_i   (trn),
    .dat_i   (sel_d),
    .rsp_o   (dly_vld),
    .dat_o   (sel_q)
  );

  // merge by delayed select, unmapped gives err with zero data
  always_comb begin
    case (sel_q)
      SEL_SRAM: begin
        tgt_rsp = sram_rsp_i;
        rdt_o   = sram_rdt_i;
        err_o   = sram_err_i;
      end
      SEL_REGS: begin
        tgt_rsp = regs_rsp_i;
        rdt_o   = regs_rdt_i;
        err_o   = regs_err_i;
      end
      default: begin
        tgt_rsp = dly_vld;
        rdt_o   = '0;
        err_o   = 1'b1;
      end
    endcase
  end

  assign rsp_o = dly_vld;

  // selected target answers in step with the decoder pipeline
  a_rsp_sync: assert property (
    @(posedge tcb) disable iff (!rst_n_i) tgt_rsp == dly_vld
  );

endmodule: tcb_dec

// ==== tcb_regs.sv ====
//////////////////////////////
// TCB register block target
// three scratch registers and a read-only ID
//////////////////////////////

`timescale 1ns/1ps

module tcb_regs #(
  // response delay
  parameter int unsigned DLY = 1
)(
  input  logic                              tcb,
  input  logic                              rst_n_i,
  // request
  input  logic                              vld_i,
  input  logic                              wen_i,
  input  logic [tcb_sub_pkg::TCB_ABW-1:0]   adr_i,
  input  logic [tcb_sub_pkg::TCB_BEW-1:0]   ben_i,
  input  logic [tcb_sub_pkg::TCB_DBW-1:0]   wdt_i,
  // response
  output logic                              rsp_o,
  output logic [tcb_sub_pkg::TCB_DBW-1:0]   rdt_o,
  output logic                              err_o
);

  import tcb_sub_pkg::*;

  // register index from the word address
  logic [1:0]         idx;
  // register 3 is the ID
  logic               id_sel;
  // scratch registers 0 to 2
  logic [TCB_DBW-1:0] scr [0:2];
  // read mux output
  logic [TCB_DBW-1:0] rd_dat;
  // response payload, error bit on top
  logic [TCB_DBW:0]   pay_d;
  logic [TCB_DBW:0]   pay_q;

  assign idx    = adr_i[3:2];
  assign id_sel = (idx == 2'd3);

//////////////////////////////
// scratch registers
//////////////////////////////

  always_ff @(posedge tcb or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 3; i++) begin
        scr[i] <= '0;
      end
    end else if (vld_i && wen_i && !id_sel) begin
      for (int b = 0; b < TCB_BEW; b++) begin
        if (ben_i[b]) begin
          scr[idx][8*b+:8] <= wdt_i[8*b+:8];
        end
      end
    end
  end

  // read mux, old value on a same-cycle write
  always_comb begin
    case (idx)
      2'd0:    rd_dat = scr[0];
      2'd1:    rd_dat = scr[1];
      2'd2:    rd_dat = scr[2];
      default: rd_dat = REGS_ID;
    endcase
  end

  // write to the ID register is refused with an error
  assign pay_d = {wen_i & id_sel, (wen_i ? {TCB_DBW{1'b0}} : rd_dat)};

  tcb_rsp_dly #(
    .DLY       (DLY),
    .payload_t (logic [TCB_DBW:0])
  ) u_rsp_dly (
    .tcb     (tcb),
    .rst_n_i (rst_n_i),
    .trn_i   (vld_i),
    .dat_i   (pay_d),
    .rsp_o   (rsp_o),
    .dat_o   (pay_q)
  );

  assign rdt_o = pay_q[TCB_DBW-1:0];
  assign err_o = pay_q[TCB_DBW];

  // a write with no byte enabled is a manager fault
  a_wr_ben: assert property (
    @(posedge tcb) disable iff (!rst_n_i) (vld_i && wen_i) |-> (ben_i != '0)
  );

endmodule: tcb_regs

// ==== tcb_rsp_dly.sv ====
//////////////////////////////
// TCB response delay pipeline
// carries a payload DLY cycles after a transfer
//////////////////////////////

`timescale 1ns/1ps

module tcb_rsp_dly #(
  // response delay in clock cycles
  parameter int unsigned DLY = 1,
  // payload carried along with the valid bit
  parameter type payload_t = logic
)(
  input  logic     tcb,
  input  logic     rst_n_i,
  // transfer strobe and its payload
  input  logic     trn_i,
  input  payload_t dat_i,
  // delayed response
  output logic     rsp_o,
  output payload_t dat_o
);

  // zero delay has no pipeline stage to hold the response
  if (DLY < 1) begin: g_dly_chk
    $error("tcb_rsp_dly: DLY must be at least 1");
  end

//////////////////////////////
// pipeline stages
//////////////////////////////

  logic     pip_vld [0:DLY-1];
  payload_t pip_dat [0:DLY-1];

  // valid bit shifts every cycle, so back-to-back transfers stay in flight
  always_ff @(posedge tcb or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DLY; i++) begin
        pip_vld[i] <= 1'b0;
      end
    end else begin
      pip_vld[0] <= trn_i;
      for (int i = 1; i < DLY; i++) begin
        pip_vld[i] <= pip_vld[i-1];
      end
    end
  end

  // first payload stage loads only on a transfer
  always_ff @(posedge tcb) begin
    if (trn_i) begin
      pip_dat[0] <= dat_i;
    end
    // later stages follow the valid bit
    for (int i = 1; i < DLY; i++) begin
      pip_dat[i] <= pip_dat[i-1];
    end
  end

  assign rsp_o = pip_vld[DLY-1];
  assign dat_o = pip_dat[DLY-1];

endmodule: tcb_rsp_dly

// ==== tcb_sram.sv ====
//////////////////////////////
// TCB SRAM target
// byte-enabled writes, fixed-delay read data
//////////////////////////////

`timescale 1ns/1ps

module tcb_sram #(
  // response delay
  parameter int unsigned DLY = 1
)(
  input  logic                              tcb,
  input  logic                              rst_n_i,
  // request
  input  logic                              vld_i,
  input  logic                              wen_i,
  input  logic [tcb_sub_pkg::TCB_ABW-1:0]   adr_i,
  input  logic [tcb_sub_pkg::TCB_BEW-1:0]   ben_i,
  input  logic [tcb_sub_pkg::TCB_DBW-1:0]   wdt_i,
  // response
  output logic                              rsp_o,
  output logic [tcb_sub_pkg::TCB_DBW-1:0]   rdt_o,
  output logic                              err_o
);

  import tcb_sub_pkg::*;

//////////////////////////////
// storage
//////////////////////////////

  // 512 words of data width
  logic [TCB_DBW-1:0] mem [0:2**SRAM_AW-1];

  // word address, byte offset dropped
  logic [SRAM_AW-1:0] wrd;

  // response payload, error bit on top of the read data
  logic [TCB_DBW:0] pay_d;
  logic [TCB_DBW:0] pay_q;

  assign wrd = adr_i[SRAM_AW+1:2];

  // only enabled bytes change
  always_ff @(posedge tcb) begin
    if (vld_i && wen_i) begin
      for (int b = 0; b < TCB_BEW; b++) begin
        if (ben_i[b]) begin
          mem[wrd][8*b+:8] <= wdt_i[8*b+:8];
        end
      end
    end
  end

//////////////////////////////
// response
//////////////////////////////

  // word read before the write at the same edge
  // write responses carry zero data
  // sram never flags an error
  assign pay_d = {1'b0, (wen_i ? {TCB_DBW{1'b0}} : mem[wrd])};

  tcb_rsp_dly #(
    .DLY       (DLY),
    .payload_t (logic [TCB_DBW:0])
  ) u_rsp_dly (
    .tcb     (tcb),
    .rst_n_i (rst_n_i),
    .trn_i   (vld_i),
    .dat_i   (pay_d),
    .rsp_o   (rsp_o),
    .dat_o   (pay_q)
  );

  assign rdt_o = pay_q[TCB_DBW-1:0];
  assign err_o = pay_q[TCB_DBW];

endmodule: tcb_sram

// ==== tcb_sub_pkg.sv ====
//////////////////////////////
// TCB subordinate subsystem package
// bus widths, address map and ID value
//////////////////////////////

package tcb_sub_pkg;

//////////////////////////////
// bus widths
//////////////////////////////

  // byte address width
  localparam int unsigned TCB_ABW = 12;
  // data width
  localparam int unsigned TCB_DBW = 32;
  // byte enable width, one bit per byte
  localparam int unsigned TCB_BEW = TCB_DBW / 8;

//////////////////////////////
// address map
//////////////////////////////

  // sram word address width, 512 words at 0x000-0x7ff
  localparam int unsigned SRAM_AW = 9;

  // register block window, 0x800-0x80f
  localparam logic [TCB_ABW-1:0] REGS_BASE = 12'h800;
  localparam logic [TCB_ABW-1:0] REGS_MASK = 12'hff0;

  // value of the read-only ID register (register 3)
  localparam logic [TCB_DBW-1:0] REGS_ID = 32'h7cb5_0b01;

endpackage: tcb_sub_pkg

// ==== tcb_tb.sv ====
//////////////////////////////
// TCB subsystem testbench
// table-driven requests, checked responses
//////////////////////////////

`timescale 1ns/1ps

module tcb_tb;

  import tcb_sub_pkg::*;

  // response delay under test
  localparam int unsigned DLY = 2;

  // clock starts low without an edge at time zero
  logic                tcb = 1'b0;
  logic                rst_n_i;
  logic                vld_i;
  logic                wen_i;
  logic [TCB_ABW-1:0]  adr_i;
  logic [TCB_BEW-1:0]  ben_i;
  logic [TCB_DBW-1:0]  wdt_i;
  logic                rdy_o;
  logic                rsp_o;
  logic [TCB_DBW-1:0]  rdt_o;
  logic                err_o;

  // stimulus table and expected response per entry
  logic                t_wen [$];
  logic [TCB_ABW-1:0]  t_adr [$];
  logic [TCB_BEW-1:0]  t_ben [$];
  logic [TCB_DBW-1:0]  t_wdt [$];
  logic [TCB_DBW-1:0]  t_rdt [$];
  logic                t_err [$];

  // reference state for building expected values
  logic [TCB_DBW-1:0]  sram_m [0:511];
  logic [TCB_DBW-1:0]  regs_m [0:2];

  // negedge of each accepted request
  int                  iss_cyc [$];
  int                  n_ent = 0;
  int                  rsp_cnt = 0;
  int                  ncyc = 0;
  int                  limit = 0;

  tcb_top #(
    .DLY (DLY)
  ) dut (
    .tcb     (tcb),
    .rst_n_i (rst_n_i),
    .vld_i   (vld_i),
    .wen_i   (wen_i),
    .adr_i   (adr_i),
    .ben_i   (ben_i),
    .wdt_i   (wdt_i),
    .rdy_o   (rdy_o),
    .rsp_o   (rsp_o),
    .rdt_o   (rdt_o),
    .err_o   (err_o)
  );

  // 40 ns period
  always #20 tcb = ~tcb;

//////////////////////////////
// helpers
//////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // byte-enabled merge of new data into an old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdt,
                                              input logic [3:0] ben);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) begin
        res[8*b+:8] = wdt[8*b+:8];
      end
    end
    return res;
  endfunction

  // one table entry, expected values from the address map rules
  task automatic add_entry(input logic wen, input logic [11:0] adr, input logic [3:0] ben,
                           input logic [31:0] wdt);
    logic [31:0] rdt;
    logic        err;
    rdt = 32'h0;
    err = 1'b0;
    if (adr < 12'h800) begin
      if (wen) begin
        sram_m[adr[10:2]] = merge_bytes(sram_m[adr[10:2]], wdt, ben);
      end else begin
        rdt = sram_m[adr[10:2]];
      end
    end else if (adr <= 12'h80f) begin
      // register 3 is the read-only ID
      if (adr[3:2] == 2'd3) begin
        if (wen) begin
          err = 1'b1;
        end else begin
          rdt = REGS_ID;
        end
      end else if (wen) begin
        regs_m[adr[3:2]] = merge_bytes(regs_m[adr[3:2]], wdt, ben);
      end else begin
        rdt = regs_m[adr[3:2]];
      end
    end else begin
      // unmapped
      err = 1'b1;
    end
    t_wen.push_back(wen);
    t_adr.push_back(adr);
    t_ben.push_back(ben);
    t_wdt.push_back(wdt);
    t_rdt.push_back(rdt);
    t_err.push_back(err);
  endtask

  task automatic build_table();
    for (int i = 0; i < 3; i++) begin
      regs_m[i] = 32'h0;
    end
    // sram full words, partial merges, read back
    add_entry(1'b1, 12'h000, 4'hf, $urandom());
    add_entry(1'b1, 12'h004, 4'hf, $urandom());
    add_entry(1'b1, 12'h7fc, 4'hf, $urandom());
    add_entry(1'b0, 12'h000, 4'hf, 32'h0);
    add_entry(1'b1, 12'h004, 4'b0101, $urandom());
    add_entry(1'b1, 12'h000, 4'b1000, $urandom());
    add_entry(1'b0, 12'h004, 4'hf, 32'h0);
    add_entry(1'b0, 12'h000, 4'hf, 32'h0);
    add_entry(1'b0, 12'h7fc, 4'hf, 32'h0);
    // random fill, back to back
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b1, 12'h100 + 12'(16 * i), 4'hf, $urandom());
    end
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 12'h100 + 12'(16 * i), 4'hf, 32'h0);
    end
    // scratch registers, reset value first
    add_entry(1'b0, 12'h800, 4'hf, 32'h0);
    add_entry(1'b1, 12'h800, 4'hf, $urandom());
    add_entry(1'b1, 12'h804, 4'b0011, $urandom());
    add_entry(1'b1, 12'h808, 4'b1100, $urandom());
    add_entry(1'b0, 12'h800, 4'hf, 32'h0);
    add_entry(1'b0, 12'h804, 4'hf, 32'h0);
    add_entry(1'b0, 12'h808, 4'hf, 32'h0);
    add_entry(1'b0, 12'h80c, 4'hf, 32'h0);
    // ID register refuses writes
    add_entry(1'b1, 12'h80c, 4'hf, $urandom());
    add_entry(1'b0, 12'h80c, 4'hf, 32'h0);
    // unmapped, then re-read earlier data
    add_entry(1'b0, 12'h810, 4'hf, 32'h0);
    add_entry(1'b1, 12'h810, 4'hf, $urandom());
    add_entry(1'b0, 12'hc00, 4'hf, 32'h0);
    add_entry(1'b1, 12'hc00, 4'hf, $urandom());
    add_entry(1'b0, 12'h000, 4'hf, 32'h0);
    add_entry(1'b0, 12'h800, 4'hf, 32'h0);
    n_ent = t_wen.size();
    limit = n_ent + DLY + 10;
  endtask

//////////////////////////////
// stimulus
//////////////////////////////

  initial begin
    void'($urandom(32'hd67f));
    rst_n_i = 1'b0;
    vld_i   = 1'b0;
    wen_i   = 1'b0;
    adr_i   = '0;
    ben_i   = '0;
    wdt_i   = '0;
    build_table();
    repeat (2) @(posedge tcb);
    rst_n_i <= 1'b1;
    // wait for ready, the timeout bounds this
    @(negedge tcb);
    while (!rdy_o) begin
      @(negedge tcb);
    end
    for (int i = 0; i < n_ent; i++) begin
      @(posedge tcb);
      vld_i <= 1'b1;
      wen_i <= t_wen[i];
      adr_i <= t_adr[i];
      ben_i <= t_ben[i];
      wdt_i <= t_wdt[i];
    end
    @(posedge tcb);
    vld_i <= 1'b0;
    wen_i <= 1'b0;
    while (rsp_cnt < n_ent) begin
      @(posedge tcb);
    end
    // a few idle cycles to catch stray responses
    repeat (2) @(negedge tcb);
    if (rsp_cnt == n_ent && iss_cyc.size() == n_ent) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("request and response counts differ from the table length");
      abort_run();
    end
  end

//////////////////////////////
// response monitor
//////////////////////////////

  // negedge sampling, all DUT outputs settled
  always @(negedge tcb) begin
    ncyc = ncyc + 1;
    if (ncyc > limit) begin
      $display("timeout, responses missing");
      abort_run();
    end else if (!rst_n_i) begin
      compare("rdy_o", {31'd0, rdy_o}, 32'd0);
      compare("rsp_o", {31'd0, rsp_o}, 32'd0);
    end else begin
      // request taken at the next rising edge
      if (vld_i && rdy_o) begin
        iss_cyc.push_back(ncyc);
      end
      if (rsp_o) begin
        if (rsp_cnt >= n_ent) begin
          $display("response arrived without a matching request");
          abort_run();
        end else begin
          compare("rsp_o cycle", ncyc, iss_cyc[rsp_cnt] + DLY);
          compare("rdt_o", rdt_o, t_rdt[rsp_cnt]);
          compare("err_o", {31'd0, err_o}, {31'd0, t_err[rsp_cnt]});
          rsp_cnt = rsp_cnt + 1;
        end
      end else if (rsp_cnt < iss_cyc.size() && ncyc >= iss_cyc[rsp_cnt] + DLY) begin
        $display("response did not arrive in its expected cycle");
        abort_run();
      end
    end
  end

endmodule: tcb_tb

// ==== tcb_top.sv ====
//////////////////////////////
// TCB subordinate subsystem top
// decoder with SRAM and register targets
//////////////////////////////

`timescale 1ns/1ps

module tcb_top #(
  // response delay, at least 1
  parameter int unsigned DLY = 1
)(
  input  logic                              tcb,
  input  logic                              rst_n_i,
  // request
  input  logic                              vld_i,
  input  logic                              wen_i,
  input  logic [tcb_sub_pkg::TCB_ABW-1:0]   adr_i,
  input  logic [tcb_sub_pkg::TCB_BEW-1:0]   ben_i,
  input  logic [tcb_sub_pkg::TCB_DBW-1:0]   wdt_i,
  output logic                              rdy_o,
  // response
  output logic                              rsp_o,
  output logic [tcb_sub_pkg::TCB_DBW-1:0]   rdt_o,
  output logic                              err_o
);

  import tcb_sub_pkg::*;

  // target request valids
  logic               sram_vld;
  logic               regs_vld;
  // target responses
  logic               sram_rsp;
  logic [TCB_DBW-1:0] sram_rdt;
  logic               sram_err;
  logic               regs_rsp;
  logic [TCB_DBW-1:0] regs_rdt;
  logic               regs_err;

//////////////////////////////
// decoder
//////////////////////////////

  tcb_dec #(
    .DLY (DLY)
  ) u_dec (
    .tcb        (tcb),
    .rst_n_i    (rst_n_i),
    .vld_i      (vld_i),
    .adr_i      (adr_i),
    .rdy_o      (rdy_o),
    .rsp_o      (rsp_o),
    .rdt_o      (rdt_o),
    .err_o      (err_o),
    .sram_vld_o (sram_vld),
    .regs_vld_o (regs_vld),
    .sram_rsp_i (sram_rsp),
    .sram_rdt_i (sram_rdt),
    .sram_err_i (sram_err),
    .regs_rsp_i (regs_rsp),
    .regs_rdt_i (regs_rdt),
    .regs_err_i (regs_err)
  );

//////////////////////////////
// targets
//////////////////////////////

  // wen, adr, ben, wdt go to both targets as is
  tcb_sram #(
    .DLY (DLY)
  ) u_sram (
    .tcb     (tcb),
    .rst_n_i (rst_n_i),
    .vld_i   (sram_vld),
    .wen_i   (wen_i),
    .adr_i   (adr_i),
    .ben_i   (ben_i),
    .wdt_i   (wdt_i),
    .rsp_o   (sram_rsp),
    .rdt_o   (sram_rdt),
    .err_o   (sram_err)
  );

  tcb_regs #(
    .DLY (DLY)
  ) u_regs (
    .tcb     (tcb),
    .rst_n_i (rst_n_i),
    .vld_i   (regs_vld),
    .wen_i   (wen_i),
    .adr_i   (adr_i),
    .ben_i   (ben_i),
    .wdt_i   (wdt_i),
    .rsp_o   (regs_rsp),
    .rdt_o   (regs_rdt),
    .err_o   (regs_err)
  );

endmodule: tcb_top
